// ==== design/axi_demux_pkg.sv ====
package axi_demux_pkg;

    localparam int OUTPUT_NUM = 3;

    localparam int ID_WIDTH   = 4;
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;

    localparam int AX_FIFO_LEN = 4;
    localparam int W_FIFO_LEN  = 4;

    // Inclusive ID ranges, one per port except the last
    localparam int unsigned ID_LO [OUTPUT_NUM-1] = '{0, 4};
    localparam int unsigned ID_HI [OUTPUT_NUM-1] = '{3, 7};

    typedef logic [ID_WIDTH-1:0]             id_t;
    typedef logic [ADDR_WIDTH-1:0]           addr_t;
    typedef logic [DATA_WIDTH-1:0]           data_t;
    typedef logic [DATA_WIDTH/8-1:0]         strb_t;
    typedef logic [7:0]                      burst_len_t;
    typedef logic [$clog2(OUTPUT_NUM)-1:0]   port_sel_t;

    // Shared by AW and AR
    typedef struct packed {
        id_t        id;
        addr_t      addr;
        burst_len_t len;
        logic [2:0] size;
        logic [1:0] burst;
    } ax_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_chan_t;

    typedef struct packed {
        id_t id;
    } b_chan_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        logic  last;
    } r_chan_t;

    // First matching range wins, anything else goes to the last port
    function automatic port_sel_t port_of_id(id_t id);
        port_sel_t sel;
        logic      found;
        sel   = port_sel_t'(OUTPUT_NUM - 1);
        found = 1'b0;
        for (int i = 0; i < OUTPUT_NUM - 1; i++) begin
            if (!found && (32'(id) >= ID_LO[i]) && (32'(id) <= ID_HI[i])) begin
                sel   = port_sel_t'(i);
                found = 1'b1;
            end
        end
        return sel;
    endfunction

endpackage

// ==== design/stream_fifo.sv ====
`timescale 1ns/10ps

module stream_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_LEN   = 4
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,

    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  valid_i,
    output logic                  ready_o,

    output logic [DATA_WIDTH-1:0] data_o,
    output logic                  valid_o,
    input  logic                  ready_i
);

    localparam int PTR_W = (FIFO_LEN > 1) ? $clog2(FIFO_LEN) : 1;
    localparam int CNT_W = $clog2(FIFO_LEN + 1);

    logic [DATA_WIDTH-1:0] mem [FIFO_LEN];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  push;
    logic                  pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_LEN - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Input side only looks at the fill level
    assign ready_o = (count != CNT_W'(FIFO_LEN));
    assign valid_o = (count != '0);
    assign push    = valid_i && ready_o;
    assign pop     = valid_o && ready_i;
    assign data_o  = mem[rd_ptr];

    always_ff @(posedge ACLK) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== design/stream_arbiter.sv ====
`timescale 1ns/10ps

module stream_arbiter #(
    parameter int DATA_WIDTH = 4
) (
    input  logic                                 ACLK,
    input  logic                                 ARESETn,

    input  logic [DATA_WIDTH-1:0]                data_i [axi_demux_pkg::OUTPUT_NUM],
    input  logic [axi_demux_pkg::OUTPUT_NUM-1:0] valid_i,
    output logic [axi_demux_pkg::OUTPUT_NUM-1:0] ready_o,

    output logic [DATA_WIDTH-1:0]                data_o,
    output logic                                 valid_o,
    input  logic                                 ready_i
);

    import axi_demux_pkg::*;

    port_sel_t rr_ptr;
    port_sel_t grant_q;
    logic      locked;
    port_sel_t pick;
    port_sel_t cand;
    logic      found;
    port_sel_t sel;

    function automatic port_sel_t wrap_add(port_sel_t base, int off);
        int sum;
        sum = int'(base) + off;
        if (sum >= OUTPUT_NUM) begin
            sum = sum - OUTPUT_NUM;
        end
        return port_sel_t'(sum);
    endfunction

    // Search starts one past the last winner
    always_comb begin
        pick  = rr_ptr;
        cand  = rr_ptr;
        found = 1'b0;
        for (int off = 1; off <= OUTPUT_NUM; off++) begin
            cand = wrap_add(rr_ptr, off);
            if (!found && valid_i[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign sel     = locked ? grant_q : pick;
    assign valid_o = locked ? valid_i[grant_q] : found;
    assign data_o  = data_i[sel];

    always_comb begin
        ready_o      = '0;
        ready_o[sel] = ready_i;
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            rr_ptr  <= port_sel_t'(OUTPUT_NUM - 1);
            grant_q <= '0;
            locked  <= 1'b0;
        end else if (valid_o) begin
            if (ready_i) begin
                locked <= 1'b0;
                rr_ptr <= sel;
            end else begin
                // Stalled, keep the same winner
                locked  <= 1'b1;
                grant_q <= sel;
            end
        end
    end

endmodule

// ==== design/write_router.sv ====
`timescale 1ns/10ps

module write_router (
    input  logic                                 ACLK,
    input  logic                                 ARESETn,

    input  axi_demux_pkg::ax_chan_t              aw_i,
    input  logic                                 aw_valid_i,
    output logic                                 aw_ready_o,

    input  axi_demux_pkg::w_chan_t               w_i,
    input  logic                                 w_valid_i,
    output logic                                 w_ready_o,

    output axi_demux_pkg::ax_chan_t              aw_o [axi_demux_pkg::OUTPUT_NUM],
    output logic [axi_demux_pkg::OUTPUT_NUM-1:0] aw_valid_o,
    input  logic [axi_demux_pkg::OUTPUT_NUM-1:0] aw_ready_i,

    output axi_demux_pkg::w_chan_t               w_o [axi_demux_pkg::OUTPUT_NUM],
    output logic [axi_demux_pkg::OUTPUT_NUM-1:0] w_valid_o,
    input  logic [axi_demux_pkg::OUTPUT_NUM-1:0] w_ready_i
);

    import axi_demux_pkg::*;

    typedef enum logic {
        ST_WAIT_ADDR,
        ST_PASS_DATA
    } state_t;

    state_t    state;
    port_sel_t sel_q;
    port_sel_t aw_sel;
    logic      w_last_seen;
    logic      w_open;
    logic      aw_xfer;
    logic      w_xfer;

    assign aw_sel = port_of_id(aw_i.id);

    // Before the AW goes out, W may only run ahead within the head burst
    assign w_open = (state == ST_PASS_DATA) || (aw_valid_i && !w_last_seen);

    always_comb begin
        aw_valid_o = '0;
        w_valid_o  = '0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        // Payload fans out to every port, only valid is steered
        for (int i = 0; i < OUTPUT_NUM; i++) begin
            aw_o[i] = aw_i;
            w_o[i]  = w_i;
        end
        if (state == ST_WAIT_ADDR) begin
            aw_valid_o[aw_sel] = aw_valid_i;
            aw_ready_o         = aw_ready_i[aw_sel];
            w_valid_o[aw_sel]  = w_valid_i && w_open;
            w_ready_o          = w_ready_i[aw_sel] && w_open;
        end else begin
            w_valid_o[sel_q] = w_valid_i;
            w_ready_o        = w_ready_i[sel_q];
        end
    end

    assign aw_xfer = aw_valid_i && aw_ready_o;
    assign w_xfer  = w_valid_i && w_ready_o;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state       <= ST_WAIT_ADDR;
            sel_q       <= '0;
            w_last_seen <= 1'b0;
        end else begin
            case (state)
                ST_WAIT_ADDR: begin
                    if (aw_xfer) begin
                        sel_q       <= aw_sel;
                        w_last_seen <= 1'b0;
                        // Burst already complete when its last beat went first
                        if (!w_last_seen && !(w_xfer && w_i.last)) begin
                            state <= ST_PASS_DATA;
                        end
                    end else if (w_xfer && w_i.last) begin
                        w_last_seen <= 1'b1;
                    end
                end
                ST_PASS_DATA: begin
                    if (w_xfer && w_i.last) begin
                        state <= ST_WAIT_ADDR;
                    end
                end
                default: begin
                    state <= ST_WAIT_ADDR;
                end
            endcase
        end
    end

endmodule

// ==== design/axi_demux.sv ====
`timescale 1ns/10ps

module axi_demux (
    input  logic                                 ACLK,
    input  logic                                 ARESETn,

    // Manager side
    input  axi_demux_pkg::ax_chan_t              s_aw_i,
    input  logic                                 s_aw_valid_i,
    output logic                                 s_aw_ready_o,

    input  axi_demux_pkg::w_chan_t               s_w_i,
    input  logic                                 s_w_valid_i,
    output logic                                 s_w_ready_o,

    output axi_demux_pkg::b_chan_t               s_b_o,
    output logic                                 s_b_valid_o,
    input  logic                                 s_b_ready_i,

    input  axi_demux_pkg::ax_chan_t              s_ar_i,
    input  logic                                 s_ar_valid_i,
    output logic                                 s_ar_ready_o,

    output axi_demux_pkg::r_chan_t               s_r_o,
    output logic                                 s_r_valid_o,
    input  logic                                 s_r_ready_i,

    // Downstream ports
    output axi_demux_pkg::ax_chan_t              m_aw_o [axi_demux_pkg::OUTPUT_NUM],
    output logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_aw_valid_o,
    input  logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_aw_ready_i,

    output axi_demux_pkg::w_chan_t               m_w_o [axi_demux_pkg::OUTPUT_NUM],
    output logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_w_valid_o,
    input  logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_w_ready_i,

    input  axi_demux_pkg::b_chan_t               m_b_i [axi_demux_pkg::OUTPUT_NUM],
    input  logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_b_valid_i,
    output logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_b_ready_o,

    output axi_demux_pkg::ax_chan_t              m_ar_o [axi_demux_pkg::OUTPUT_NUM],
    output logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_ar_valid_o,
    input  logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_ar_ready_i,

    input  axi_demux_pkg::r_chan_t               m_r_i [axi_demux_pkg::OUTPUT_NUM],
    input  logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_r_valid_i,
    output logic [axi_demux_pkg::OUTPUT_NUM-1:0] m_r_ready_o
);

    import axi_demux_pkg::*;

    ax_chan_t  aw_q;
    logic      aw_q_valid;
    logic      aw_q_ready;
    w_chan_t   w_q;
    logic      w_q_valid;
    logic      w_q_ready;
    ax_chan_t  ar_q;
    logic      ar_q_valid;
    logic      ar_q_ready;
    port_sel_t ar_sel;

    stream_fifo #(
        .DATA_WIDTH($bits(ax_chan_t)),
        .FIFO_LEN  (AX_FIFO_LEN)
    ) i_fifo_aw (
        .ACLK   (ACLK),
        .ARESETn(ARESETn),
        .data_i (s_aw_i),
        .valid_i(s_aw_valid_i),
        .ready_o(s_aw_ready_o),
        .data_o (aw_q),
        .valid_o(aw_q_valid),
        .ready_i(aw_q_ready)
    );

    stream_fifo #(
        .DATA_WIDTH($bits(w_chan_t)),
        .FIFO_LEN  (W_FIFO_LEN)
    ) i_fifo_w (
        .ACLK   (ACLK),
        .ARESETn(ARESETn),
        .data_i (s_w_i),
        .valid_i(s_w_valid_i),
        .ready_o(s_w_ready_o),
        .data_o (w_q),
        .valid_o(w_q_valid),
        .ready_i(w_q_ready)
    );

    stream_fifo #(
        .DATA_WIDTH($bits(ax_chan_t)),
        .FIFO_LEN  (AX_FIFO_LEN)
    ) i_fifo_ar (
        .ACLK   (ACLK),
        .ARESETn(ARESETn),
        .data_i (s_ar_i),
        .valid_i(s_ar_valid_i),
        .ready_o(s_ar_ready_o),
        .data_o (ar_q),
        .valid_o(ar_q_valid),
        .ready_i(ar_q_ready)
    );

    write_router i_write_router (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .aw_i      (aw_q),
        .aw_valid_i(aw_q_valid),
        .aw_ready_o(aw_q_ready),
        .w_i       (w_q),
        .w_valid_i (w_q_valid),
        .w_ready_o (w_q_ready),
        .aw_o      (m_aw_o),
        .aw_valid_o(m_aw_valid_o),
        .aw_ready_i(m_aw_ready_i),
        .w_o       (m_w_o),
        .w_valid_o (m_w_valid_o),
        .w_ready_i (m_w_ready_i)
    );

    // Reads need no held state, each request goes out on its own
    assign ar_sel     = port_of_id(ar_q.id);
    assign ar_q_ready = m_ar_ready_i[ar_sel];

    always_comb begin
        m_ar_valid_o         = '0;
        m_ar_valid_o[ar_sel] = ar_q_valid;
        for (int i = 0; i < OUTPUT_NUM; i++) begin
            m_ar_o[i] = ar_q;
        end
    end

    stream_arbiter #(
        .DATA_WIDTH($bits(b_chan_t))
    ) arb_b (
        .ACLK   (ACLK),
        .ARESETn(ARESETn),
        .data_i (m_b_i),
        .valid_i(m_b_valid_i),
        .ready_o(m_b_ready_o),
        .data_o (s_b_o),
        .valid_o(s_b_valid_o),
        .ready_i(s_b_ready_i)
    );

    stream_arbiter #(
        .DATA_WIDTH($bits(r_chan_t))
    ) arb_r (
        .ACLK   (ACLK),
        .ARESETn(ARESETn),
        .data_i (m_r_i),
        .valid_i(m_r_valid_i),
        .ready_o(m_r_ready_o),
        .data_o (s_r_o),
        .valid_o(s_r_valid_o),
        .ready_i(s_r_ready_i)
    );

endmodule

// ==== bench/tb_axi_demux.sv ====
`timescale 1ns/10ps

module tb_axi_demux;

    import axi_demux_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int ID_SPACE   = 1 << ID_WIDTH;
    localparam int N_WR       = 40;
    localparam int N_RD       = 40;
    localparam int MAX_BEATS  = 4;
    // Reset and directed traffic, then about six cycles per random beat
    localparam int EST_CYCLES     = 80 + (N_WR + N_RD) * MAX_BEATS * 6;
    localparam int TIMEOUT_CYCLES = 2 * EST_CYCLES;

    logic ACLK;
    logic ARESETn;

    ax_chan_t s_aw;
    logic     s_aw_valid;
    logic     s_aw_ready;
    w_chan_t  s_w;
    logic     s_w_valid;
    logic     s_w_ready;
    b_chan_t  s_b;
    logic     s_b_valid;
    logic     s_b_ready;
    ax_chan_t s_ar;
    logic     s_ar_valid;
    logic     s_ar_ready;
    r_chan_t  s_r;
    logic     s_r_valid;
    logic     s_r_ready;

    ax_chan_t                m_aw [OUTPUT_NUM];
    logic [OUTPUT_NUM-1:0]   m_aw_valid;
    logic [OUTPUT_NUM-1:0]   m_aw_ready;
    w_chan_t                 m_w [OUTPUT_NUM];
    logic [OUTPUT_NUM-1:0]   m_w_valid;
    logic [OUTPUT_NUM-1:0]   m_w_ready;
    b_chan_t                 m_b [OUTPUT_NUM];
    logic [OUTPUT_NUM-1:0]   m_b_valid;
    logic [OUTPUT_NUM-1:0]   m_b_ready;
    ax_chan_t                m_ar [OUTPUT_NUM];
    logic [OUTPUT_NUM-1:0]   m_ar_valid;
    logic [OUTPUT_NUM-1:0]   m_ar_ready;
    r_chan_t                 m_r [OUTPUT_NUM];
    logic [OUTPUT_NUM-1:0]   m_r_valid;
    logic [OUTPUT_NUM-1:0]   m_r_ready;

    // Stimulus still to send, and what each port and ID should see
    ax_chan_t aw_todo [$];
    w_chan_t  w_todo [$];
    ax_chan_t ar_todo [$];
    ax_chan_t exp_aw [OUTPUT_NUM][$];
    w_chan_t  exp_w [OUTPUT_NUM][$];
    ax_chan_t exp_ar [OUTPUT_NUM][$];
    int       exp_rd_len [ID_SPACE][$];

    // Subordinate model state
    id_t      sub_aw_ids [OUTPUT_NUM][$];
    id_t      sub_b [OUTPUT_NUM][$];
    ax_chan_t sub_ar [OUTPUT_NUM][$];
    int       sub_w_lasts [OUTPUT_NUM];
    int       sub_r_beat [OUTPUT_NUM];

    int rd_beat [ID_SPACE];
    int b_owed [ID_SPACE];
    int wr_total [ID_SPACE];
    int b_total [ID_SPACE];
    int rd_beats_issued;
    int rd_beats_seen;
    int errors;
    int tests_run;
    int tests_ok;
    int cycle_count;
    bit pressure;
    bit stim_started;

    logic [31:0] lfsr_state = 32'd95199;

    axi_demux i_axi_demux (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .s_aw_i      (s_aw),
        .s_aw_valid_i(s_aw_valid),
        .s_aw_ready_o(s_aw_ready),
        .s_w_i       (s_w),
        .s_w_valid_i (s_w_valid),
        .s_w_ready_o (s_w_ready),
        .s_b_o       (s_b),
        .s_b_valid_o (s_b_valid),
        .s_b_ready_i (s_b_ready),
        .s_ar_i      (s_ar),
        .s_ar_valid_i(s_ar_valid),
        .s_ar_ready_o(s_ar_ready),
        .s_r_o       (s_r),
        .s_r_valid_o (s_r_valid),
        .s_r_ready_i (s_r_ready),
        .m_aw_o      (m_aw),
        .m_aw_valid_o(m_aw_valid),
        .m_aw_ready_i(m_aw_ready),
        .m_w_o       (m_w),
        .m_w_valid_o (m_w_valid),
        .m_w_ready_i (m_w_ready),
        .m_b_i       (m_b),
        .m_b_valid_i (m_b_valid),
        .m_b_ready_o (m_b_ready),
        .m_ar_o      (m_ar),
        .m_ar_valid_o(m_ar_valid),
        .m_ar_ready_i(m_ar_ready),
        .m_r_i       (m_r),
        .m_r_valid_i (m_r_valid),
        .m_r_ready_o (m_r_ready)
    );

    initial begin
        ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
    end

    // IDs 0..3 to port 0, 4..7 to port 1, the rest to port 2
    function automatic int route_port(input id_t id);
        if (int'(id) <= 3) begin
            return 0;
        end else if (int'(id) <= 7) begin
            return 1;
        end else begin
            return 2;
        end
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic add_write(input id_t id, input burst_len_t len);
        ax_chan_t aw;
        w_chan_t  w;
        int       p;
        p        = route_port(id);
        aw.id    = id;
        aw.addr  = addr_t'(rand_bits(16));
        aw.len   = len;
        aw.size  = 3'd2;
        aw.burst = 2'b01;
        aw_todo.push_back(aw);
        exp_aw[p].push_back(aw);
        for (int i = 0; i <= int'(len); i++) begin
            w.data = data_t'(rand_bits(32));
            w.strb = '1;
            w.last = (i == int'(len));
            w_todo.push_back(w);
            exp_w[p].push_back(w);
        end
        wr_total[id]++;
    endtask

    task automatic add_read(input id_t id, input burst_len_t len);
        ax_chan_t ar;
        ar.id    = id;
        ar.addr  = addr_t'(rand_bits(16));
        ar.len   = len;
        ar.size  = 3'd2;
        ar.burst = 2'b01;
        ar_todo.push_back(ar);
        exp_ar[route_port(id)].push_back(ar);
        exp_rd_len[id].push_back(int'(len));
        rd_beats_issued += int'(len) + 1;
    endtask

    // Called one ns after an edge, returns one ns after an edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ACLK);
            #1;
        end
    endtask

    task automatic drive_aw(input int start_gap);
        repeat (start_gap) @(posedge ACLK);
        #1;
        while (aw_todo.size() != 0) begin
            s_aw       = aw_todo.pop_front();
            s_aw_valid = 1'b1;
            @(posedge ACLK);
            while (!s_aw_ready) begin
                @(posedge ACLK);
            end
            #1;
            s_aw_valid = 1'b0;
            if (pressure) begin
                idle_cycles(int'(rand_bits(2)));
            end
        end
    endtask

    task automatic drive_w();
        #1;
        while (w_todo.size() != 0) begin
            s_w       = w_todo.pop_front();
            s_w_valid = 1'b1;
            @(posedge ACLK);
            while (!s_w_ready) begin
                @(posedge ACLK);
            end
            #1;
            s_w_valid = 1'b0;
            if (pressure) begin
                idle_cycles(int'(rand_bits(1)));
            end
        end
    endtask

    task automatic drive_ar();
        #1;
        while (ar_todo.size() != 0) begin
            s_ar       = ar_todo.pop_front();
            s_ar_valid = 1'b1;
            @(posedge ACLK);
            while (!s_ar_ready) begin
                @(posedge ACLK);
            end
            #1;
            s_ar_valid = 1'b0;
            if (pressure) begin
                idle_cycles(int'(rand_bits(2)));
            end
        end
    endtask

    function automatic bit traffic_done();
        bit done;
        done = (aw_todo.size() == 0) && (w_todo.size() == 0) && (ar_todo.size() == 0);
        for (int p = 0; p < OUTPUT_NUM; p++) begin
            if (exp_aw[p].size() != 0 || exp_w[p].size() != 0 ||
                exp_ar[p].size() != 0 || sub_b[p].size() != 0) begin
                done = 1'b0;
            end
        end
        for (int i = 0; i < ID_SPACE; i++) begin
            if (exp_rd_len[i].size() != 0 || b_owed[i] != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic run_traffic(input int aw_gap);
        @(posedge ACLK);
        fork
            drive_aw(aw_gap);
            drive_w();
            drive_ar();
        join
        while (!traffic_done()) begin
            @(posedge ACLK);
        end
        for (int i = 0; i < ID_SPACE; i++) begin
            assert (b_total[i] == wr_total[i])
                else report_mismatch($sformatf("id %0d got %0d B for %0d writes",
                                               i, b_total[i], wr_total[i]));
        end
        assert (rd_beats_seen == rd_beats_issued)
            else report_mismatch($sformatf("%0d R beats seen of %0d issued",
                                           rd_beats_seen, rd_beats_issued));
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_ok++;
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d check(s) failed", name, errors - errs_before);
        end
    endtask

    idle_after_reset: assert property (@(posedge ACLK) stim_started ||
        (m_aw_valid == '0 && m_w_valid == '0 && m_ar_valid == '0 && !s_b_valid && !s_r_valid))
        else report_mismatch("valid high on an output before any stimulus");

    for (genvar p = 0; p < OUTPUT_NUM; p++) begin : g_route
        aw_routed: assert property (@(posedge ACLK) !m_aw_valid[p] || route_port(m_aw[p].id) == p)
            else report_mismatch($sformatf("AW id %0d on port %0d", m_aw[p].id, p));
        ar_routed: assert property (@(posedge ACLK) !m_ar_valid[p] || route_port(m_ar[p].id) == p)
            else report_mismatch($sformatf("AR id %0d on port %0d", m_ar[p].id, p));
    end

    // Subordinate models and manager-side response checks
    initial begin : downstream_models
        ax_chan_t ax;
        w_chan_t  w;
        id_t      id;
        int       len;
        data_t    exp_data;
        m_aw_ready = '0;
        m_w_ready  = '0;
        m_ar_ready = '0;
        m_b_valid  = '0;
        m_r_valid  = '0;
        s_b_ready  = 1'b0;
        s_r_ready  = 1'b0;
        for (int p = 0; p < OUTPUT_NUM; p++) begin
            m_b[p] = '0;
            m_r[p] = '0;
        end
        forever begin
            @(posedge ACLK);
            for (int p = 0; p < OUTPUT_NUM; p++) begin
                if (m_aw_valid[p] && m_aw_ready[p]) begin
                    assert (exp_aw[p].size() != 0 && exp_aw[p][0] == m_aw[p])
                        else report_mismatch($sformatf("AW id %0d on port %0d out of order",
                                                       m_aw[p].id, p));
                    if (exp_aw[p].size() != 0) begin
                        ax = exp_aw[p].pop_front();
                    end
                    sub_aw_ids[p].push_back(m_aw[p].id);
                end
                if (m_w_valid[p] && m_w_ready[p]) begin
                    assert (exp_w[p].size() != 0 && exp_w[p][0] == m_w[p])
                        else report_mismatch($sformatf("W beat %h on port %0d not expected",
                                                       m_w[p].data, p));
                    if (exp_w[p].size() != 0) begin
                        w = exp_w[p].pop_front();
                    end
                    if (m_w[p].last) begin
                        sub_w_lasts[p]++;
                    end
                end
                if (m_ar_valid[p] && m_ar_ready[p]) begin
                    assert (exp_ar[p].size() != 0 && exp_ar[p][0] == m_ar[p])
                        else report_mismatch($sformatf("AR id %0d on port %0d out of order",
                                                       m_ar[p].id, p));
                    if (exp_ar[p].size() != 0) begin
                        ax = exp_ar[p].pop_front();
                    end
                    sub_ar[p].push_back(m_ar[p]);
                end
                if (m_b_valid[p] && m_b_ready[p]) begin
                    id = sub_b[p].pop_front();
                end
                if (m_r_valid[p] && m_r_ready[p]) begin
                    ax = sub_ar[p][0];
                    if (sub_r_beat[p] == int'(ax.len)) begin
                        ax            = sub_ar[p].pop_front();
                        sub_r_beat[p] = 0;
                    end else begin
                        sub_r_beat[p]++;
                    end
                end
                // A write completes once its address and last beat are both in
                while (sub_aw_ids[p].size() != 0 && sub_w_lasts[p] != 0) begin
                    id = sub_aw_ids[p].pop_front();
                    sub_w_lasts[p]--;
                    sub_b[p].push_back(id);
                    b_owed[id]++;
                end
            end
            if (s_b_valid && s_b_ready) begin
                assert (b_owed[s_b.id] > 0)
                    else report_mismatch($sformatf("B id %0d without a completed write", s_b.id));
                if (b_owed[s_b.id] > 0) begin
                    b_owed[s_b.id]--;
                end
                b_total[s_b.id]++;
            end
            if (s_r_valid && s_r_ready) begin
                id = s_r.id;
                rd_beats_seen++;
                assert (exp_rd_len[id].size() != 0)
                    else report_mismatch($sformatf("R id %0d with no read open", id));
                if (exp_rd_len[id].size() != 0) begin
                    len      = exp_rd_len[id][0];
                    exp_data = data_t'(int'(id) * 256 + route_port(id) * 16 + rd_beat[id]);
                    assert (s_r.data == exp_data && s_r.last == (rd_beat[id] == len))
                        else report_mismatch($sformatf("R id %0d beat %0d data %h last %b",
                                                       id, rd_beat[id], s_r.data, s_r.last));
                    if (rd_beat[id] == len) begin
                        len         = exp_rd_len[id].pop_front();
                        rd_beat[id] = 0;
                    end else begin
                        rd_beat[id]++;
                    end
                end
            end
            #1;
            for (int p = 0; p < OUTPUT_NUM; p++) begin
                m_aw_ready[p] = pressure ? lfsr_step() : 1'b1;
                m_w_ready[p]  = pressure ? lfsr_step() : 1'b1;
                m_ar_ready[p] = pressure ? lfsr_step() : 1'b1;
                m_b_valid[p]  = (sub_b[p].size() != 0);
                if (sub_b[p].size() != 0) begin
                    m_b[p].id = sub_b[p][0];
                end
                m_r_valid[p] = (sub_ar[p].size() != 0);
                if (sub_ar[p].size() != 0) begin
                    ax           = sub_ar[p][0];
                    m_r[p].id    = ax.id;
                    m_r[p].data  = data_t'(int'(ax.id) * 256 + p * 16 + sub_r_beat[p]);
                    m_r[p].last  = (sub_r_beat[p] == int'(ax.len));
                end
            end
            s_b_ready = pressure ? lfsr_step() : 1'b1;
            s_r_ready = pressure ? lfsr_step() : 1'b1;
        end
    end

    always @(posedge ACLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin : main
        int errs_before;
        ARESETn      = 1'b0;
        s_aw         = '0;
        s_aw_valid   = 1'b0;
        s_w          = '0;
        s_w_valid    = 1'b0;
        s_ar         = '0;
        s_ar_valid   = 1'b0;
        pressure     = 1'b0;
        stim_started = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_ok     = 0;
        cycle_count  = 0;
        repeat (5) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;

        errs_before = errors;
        repeat (5) @(posedge ACLK);
        close_test("reset_idle", errs_before);
        stim_started = 1'b1;

        // AW held back so W beats sit in the FIFO first
        errs_before = errors;
        add_write(4'd1, 8'd3);
        add_write(4'd5, 8'd0);
        add_write(4'd12, 8'd2);
        add_read(4'd2, 8'd1);
        add_read(4'd6, 8'd3);
        add_read(4'd9, 8'd0);
        run_traffic(6);
        close_test("directed_routing", errs_before);

        errs_before = errors;
        pressure    = 1'b1;
        for (int i = 0; i < N_WR; i++) begin
            add_write(id_t'(rand_bits(4)), burst_len_t'(rand_bits(2)));
            add_read(id_t'(rand_bits(4)), burst_len_t'(rand_bits(2)));
        end
        run_traffic(0);
        close_test("random_backpressure", errs_before);

        $display("Tests run: %0d, passed: %0d, failed checks: %0d", tests_run, tests_ok, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/axi_demux_pkg.sv
design/stream_fifo.sv
design/stream_arbiter.sv
design/write_router.sv
design/axi_demux.sv
bench/tb_axi_demux.sv

// ==== Makefile ====
TOP := tb_axi_demux

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

lint:
	verilator --lint-only -Wall design/axi_demux_pkg.sv design/stream_fifo.sv \
		design/stream_arbiter.sv design/write_router.sv design/axi_demux.sv \
		--top-module axi_demux

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
